/* files.f */
design/uart_cmd_pkg.sv
design/uart_frame_if.sv
design/uart_tx_frame.sv
design/uart_rx_frame.sv
design/uart_cmd_ctrl.sv
design/uart_cmd_top.sv
dv/uart_cmd_assert.sv
dv/uart_cmd_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the UART bridge testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module uart_cmd_tb \
  -f files.f -o uart_cmd_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/uart_cmd_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* dv/uart_cmd_tb.sv */
`default_nettype none

module uart_cmd_tb;
  import uart_cmd_pkg::*;

  localparam int NUM_WRITES  = 4;
  localparam int NUM_CMDS    = 2 * NUM_WRITES + 2;
  localparam int WDOG_CYCLES = NUM_CMDS * (2 * 11 + 15 + 70) * BIT_CYCLES + 1000;

  // Device reply modes.
  localparam int MODE_OK      = 0;
  localparam int MODE_BAD_PAR = 1;
  localparam int MODE_SILENT  = 2;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rx;
  logic        tx;
  logic [7:0]  read_data;
  logic        read_rdy;
  logic        read_err;
  logic        read_timeout;

  int          cyc;
  int          errors;
  int          timeouts;
  logic [31:0] lfsr;
  logic [7:0]  regs [128];
  logic [7:0]  exp_bytes [$];  // Bytes the device should see in order.
  logic [6:0]  written [$];
  int          resp_mode;
  int          addr_t0;        // First low cycle of the last read address frame.

  uart_cmd_top u_uart_cmd_top (.*);

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  // Galois LFSR stepped once for each bit taken.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp)
    else
    begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic match_expected(input logic [7:0] got);
    assert (exp_bytes.size() > 0)
    else
    begin
      errors++;
      $display("Frame with byte %h appeared on tx when none was expected", got);
    end
    if (exp_bytes.size() > 0)
    begin
      compare("tx byte", 32'(got), 32'(exp_bytes.pop_front()));
    end
  endtask

  // Decode one frame from tx by sampling each bit in its middle.
  task automatic recv_frame(output logic [7:0] data, output int t0);
    logic [10:0] bits;
    int          i;
    @(negedge clk);
    while (tx !== 1'b0)
    begin
      @(negedge clk);
    end
    t0 = cyc;
    repeat (HALF_BIT_CYCLES) @(negedge clk);
    for (i = 0; i < FRAME_BITS; i++)
    begin
      bits[i] = tx;
      if (i < FRAME_BITS - 1)
      begin
        repeat (BIT_CYCLES) @(negedge clk);
      end
    end
    compare("tx start bit", 32'(bits[0]), 32'h0);
    compare("tx parity bit", 32'(bits[9]), 32'(^bits[8:1]));  // Even parity.
    compare("tx stop bit", 32'(bits[10]), 32'h1);
    data = bits[8:1];
  endtask

  task automatic send_frame(input logic [7:0] data, input logic bad_par);
    logic [10:0] bits;
    logic [31:0] r;
    int          dly;
    int          i;
    r    = take_bits(2);
    dly  = 1 + int'(r[1:0]) % 3;  // One to three bit periods.
    bits = {1'b1, (^data) ^ bad_par, data, 1'b0};
    repeat (HALF_BIT_CYCLES + dly * BIT_CYCLES) @(posedge clk);
    for (i = 0; i < FRAME_BITS; i++)
    begin
      rx <= bits[i];
      repeat (BIT_CYCLES) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  // Serial register device.
  initial
  begin : device_model
    logic [7:0] b;
    logic [7:0] d;
    int         t0;
    int         t1;
    int         i;
    for (i = 0; i < 128; i++)
    begin
      regs[i] = 8'(i) ^ 8'hc3;
    end
    forever
    begin
      recv_frame(b, t0);
      match_expected(b);
      if (b[7])
      begin
        recv_frame(d, t1);
        match_expected(d);
        assert (t1 - (t0 + FRAME_BITS * BIT_CYCLES) >= GAP_CYCLES)
        else
        begin
          errors++;
          $display("Idle gap between write frames was only %0d cycles",
                   t1 - (t0 + FRAME_BITS * BIT_CYCLES));
        end
        regs[b[6:0]] = d;
      end
      else
      begin
        addr_t0 = t0;
        if (resp_mode != MODE_SILENT)
        begin
          send_frame(regs[b[6:0]], resp_mode == MODE_BAD_PAR);
        end
      end
    end
  end

  task automatic wait_ready();
    do
    begin
      @(negedge clk);
    end
    while (!cmd_rdy);
  endtask

  task automatic issue_cmd(input cmd_word_u cmd);
    wait_ready();
    @(posedge clk);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  task automatic write_reg(input logic [6:0] addr, input logic [7:0] data, input logic bp);
    cmd_word_u cmd;
    cmd.fields.is_write = 1'b1;
    cmd.fields.addr     = addr;
    cmd.fields.wdata    = data;
    // Address byte with the write flag in bit 7, then the data byte.
    exp_bytes.push_back({1'b1, addr});
    exp_bytes.push_back(data);
    issue_cmd(cmd);
    if (bp)
    begin
      repeat (3 * BIT_CYCLES) @(posedge clk);
      cmd_in  <= ~cmd;  // Must be ignored while busy.
      cmd_vld <= 1'b1;
      @(posedge clk);
      cmd_vld <= 1'b0;
    end
    wait_ready();
    written.push_back(addr);
    repeat (2 * BIT_CYCLES) @(posedge clk);
  endtask

  task automatic read_reg(input logic [6:0] addr, input int mode);
    cmd_word_u  cmd;
    logic [7:0] got;
    int         n_rdy;
    int         n_err;
    int         n_to;
    int         t_to;
    cmd.fields.is_write = 1'b0;
    cmd.fields.addr     = addr;
    cmd.fields.wdata    = 8'h00;
    resp_mode = mode;
    exp_bytes.push_back({1'b0, addr});
    issue_cmd(cmd);
    n_rdy = 0;
    n_err = 0;
    n_to  = 0;
    t_to  = 0;
    got   = '0;
    do
    begin
      @(negedge clk);
      if (read_rdy)
      begin
        n_rdy++;
        got = read_data;
      end
      if (read_err)
      begin
        n_err++;
      end
      if (read_timeout)
      begin
        n_to++;
        t_to = cyc;
      end
    end
    while (!cmd_rdy);
    compare("read_rdy pulses", 32'(n_rdy), 32'(mode == MODE_OK));
    compare("read_err pulses", 32'(n_err), 32'(mode == MODE_BAD_PAR));
    compare("read_timeout pulses", 32'(n_to), 32'(mode == MODE_SILENT));
    if (mode == MODE_OK)
    begin
      compare("read_data", 32'(got), 32'(regs[addr]));
    end
    if (mode == MODE_SILENT)
    begin
      // Counted from the last cycle of the address frame's stop bit.
      compare("read_timeout cycle", 32'(t_to),
              32'(addr_t0 + FRAME_BITS * BIT_CYCLES - 1 + RESP_TIMEOUT_CYCLES));
    end
    repeat (2 * BIT_CYCLES) @(posedge clk);
  endtask

  task automatic end_run();
    int bound_fails;
    bound_fails = u_uart_cmd_top.u_uart_cmd_assert.fail_cnt;
    $display("Errors: %0d checks, %0d bound assertions, %0d watchdog",
             errors, bound_fails, timeouts);
    if (errors == 0 && bound_fails == 0 && timeouts == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  initial
  begin
    logic [31:0] r;
    int          i;
    clk       = 1'b0;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx        = 1'b1;
    cyc       = 0;
    errors    = 0;
    timeouts  = 0;
    lfsr      = 32'hb5ff_e58f;
    resp_mode = MODE_OK;
    addr_t0   = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    for (i = 0; i < NUM_WRITES; i++)
    begin
      r = take_bits(15);
      write_reg(r[14:8], r[7:0], i == 1);
    end
    for (i = 0; i < NUM_WRITES; i++)
    begin
      read_reg(written[i], MODE_OK);
    end
    read_reg(written[0], MODE_BAD_PAR);
    read_reg(written[1], MODE_SILENT);
    end_run();
  end

  initial
  begin
    repeat (WDOG_CYCLES) @(posedge clk);
    timeouts++;
    $display("Watchdog expired after %0d cycles before all commands finished", WDOG_CYCLES);
    end_run();
  end

endmodule

`default_nettype wire

/* dv/uart_cmd_assert.sv */
`default_nettype none

module uart_cmd_assert (
  input logic                      clk,
  input logic                      rst_n,
  input logic [15:0]               cmd_in,
  input logic                      cmd_vld,
  input logic                      cmd_rdy,
  input logic                      tx,
  input logic                      read_rdy,
  input logic                      read_err,
  input logic                      read_timeout,
  input uart_cmd_pkg::ctrl_state_e state
);
  import uart_cmd_pkg::*;

  localparam int WR_LATENCY = 2 * FRAME_BITS * BIT_CYCLES + GAP_CYCLES + 4;

  int   fail_cnt = 0;
  logic rst_q;    // Reset was low at the previous edge.
  logic wr_cmd;
  int   lat_cnt;  // Cycles since the last accepted command.

  always_ff @(posedge clk)
  begin
    rst_q <= !rst_n;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_cmd  <= 1'b0;
      lat_cnt <= 0;
    end
    else if (cmd_vld && cmd_rdy)
    begin
      wr_cmd  <= cmd_in[15];  // Write flag.
      lat_cnt <= 1;
    end
    else if (!cmd_rdy)
    begin
      lat_cnt <= lat_cnt + 1;
    end
  end

  a_reset_idle: assert property (@(posedge clk)
    rst_q |-> (tx && cmd_rdy && !read_rdy && !read_err && !read_timeout))
  else
  begin
    fail_cnt++;
    $error("outputs not idle during or right after reset");
  end

  a_status_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({read_rdy, read_err, read_timeout}))
  else
  begin
    fail_cnt++;
    $error("more than one read status pulse at once");
  end

  // Ready comes back the cycle after any read status.
  a_status_then_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (read_rdy || read_err || read_timeout) |=> cmd_rdy)
  else
  begin
    fail_cnt++;
    $error("cmd_rdy did not return after a read status pulse");
  end

  a_accept_drops_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cmd_rdy)
  else
  begin
    fail_cnt++;
    $error("cmd_rdy stayed high after a command was accepted");
  end

  a_line_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !tx |-> !cmd_rdy)
  else
  begin
    fail_cnt++;
    $error("cmd_rdy high while a frame is on tx");
  end

  // Line idles high while the controller waits between frames.
  a_idle_between_frames: assert property (@(posedge clk) disable iff (!rst_n)
    ((state == WR_GAP) || (state == RD_WAIT)) |-> tx)
  else
  begin
    fail_cnt++;
    $error("tx left idle while the controller waited between frames");
  end

  a_write_latency: assert property (@(posedge clk) disable iff (!rst_n)
    ($rose(cmd_rdy) && wr_cmd) |-> (lat_cnt == WR_LATENCY))
  else
  begin
    fail_cnt++;
    $error("write took %0d cycles instead of the fixed latency", lat_cnt);
  end

endmodule

bind uart_cmd_top uart_cmd_assert u_uart_cmd_assert (
  .state (u_uart_cmd_ctrl.state),
  .*
);

`default_nettype wire

/* design/uart_cmd_top.sv */
`default_nettype none

module uart_cmd_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] cmd_in,
  input  logic        cmd_vld,
  output logic        cmd_rdy,
  input  logic        rx,
  output logic        tx,
  output logic [7:0]  read_data,
  output logic        read_rdy,
  output logic        read_err,
  output logic        read_timeout
);

  uart_tx_if tx_link ();
  uart_rx_if rx_link ();

  // Command word is decoded by the controller.
  uart_cmd_ctrl u_uart_cmd_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_in       (cmd_in),
    .cmd_vld      (cmd_vld),
    .cmd_rdy      (cmd_rdy),
    .tx_link      (tx_link.ctrl),
    .rx_link      (rx_link.ctrl),
    .read_data    (read_data),
    .read_rdy     (read_rdy),
    .read_err     (read_err),
    .read_timeout (read_timeout)
  );

  uart_tx_frame u_uart_tx_frame (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_link (tx_link.framer),
    .tx      (tx)
  );

  uart_rx_frame u_uart_rx_frame (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_link (rx_link.framer)
  );

endmodule

`default_nettype wire

/* design/uart_cmd_ctrl.sv */
`default_nettype none

module uart_cmd_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::cmd_word_u cmd_in,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  uart_tx_if.ctrl                 tx_link,
  uart_rx_if.ctrl                 rx_link,
  output logic [7:0]              read_data,
  output logic                    read_rdy,
  output logic                    read_err,
  output logic                    read_timeout
);
  import uart_cmd_pkg::*;

  ctrl_state_e      state;
  cmd_word_u        cmd_buf;
  logic [TMR_W-1:0] tmr;
  logic             accept;

  assign accept = (state == IDLE) && cmd_vld && cmd_rdy;

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_buf <= cmd_in;
    end

    if (state == DECODE)
    begin
      tx_link.data <= cmd_buf.bytes[1];  // Write flag and address.
    end
    else if (state == WR_GAP)
    begin
      tx_link.data <= cmd_buf.bytes[0];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state          <= IDLE;
      cmd_rdy        <= 1'b1;
      tx_link.start  <= 1'b0;
      rx_link.enable <= 1'b0;
      tmr            <= '0;
      read_data      <= '0;
      read_rdy       <= 1'b0;
      read_err       <= 1'b0;
      read_timeout   <= 1'b0;
    end
    else
    begin
      tx_link.start <= 1'b0;
      read_rdy      <= 1'b0;
      read_err      <= 1'b0;
      read_timeout  <= 1'b0;

      case (state)
        IDLE:
        begin
          if (accept)
          begin
            cmd_rdy <= 1'b0;
            state   <= DECODE;
          end
        end
        DECODE:
        begin
          if (!tx_link.busy)
          begin
            tx_link.start <= 1'b1;
            state <= cmd_buf.fields.is_write ? WR_ADDR : RD_ADDR;
          end
        end
        WR_ADDR:
        begin
          if (tx_link.done)
          begin
            tmr   <= '0;
            state <= WR_GAP;
          end
        end
        WR_GAP:
        begin
          // tx drops two cycles after start, so the line idles GAP_CYCLES.
          if ((tmr == TMR_W'(GAP_CYCLES - 3)) && !tx_link.busy)
          begin
            tx_link.start <= 1'b1;
            state         <= WR_DATA;
          end
          else
          begin
            tmr <= tmr + 1'b1;
          end
        end
        WR_DATA:
        begin
          if (tx_link.done)
          begin
            cmd_rdy <= 1'b1;
            state   <= IDLE;
          end
        end
        RD_ADDR:
        begin
          if (tx_link.done)
          begin
            rx_link.enable <= 1'b1;
            tmr            <= '0;
            state          <= RD_WAIT;
          end
        end
        RD_WAIT:
        begin
          if (rx_link.valid)
          begin
            read_data      <= rx_link.data;
            read_rdy       <= 1'b1;
            rx_link.enable <= 1'b0;
            state          <= RD_DONE;
          end
          else if (rx_link.frame_err)
          begin
            read_err       <= 1'b1;
            rx_link.enable <= 1'b0;
            state          <= RD_DONE;
          end
          else if (tmr == TMR_W'(RESP_TIMEOUT_CYCLES - 2))  // Lands on the full window.
          begin
            read_timeout   <= 1'b1;
            rx_link.enable <= 1'b0;
            state          <= RD_DONE;
          end
          else
          begin
            tmr <= tmr + 1'b1;
          end
        end
        RD_DONE:
        begin
          cmd_rdy <= 1'b1;  // One cycle after the status pulse.
          state   <= IDLE;
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/uart_rx_frame.sv */
`default_nettype none

module uart_rx_frame (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  uart_rx_if.framer  rx_link
);
  import uart_cmd_pkg::*;

  logic                 rx_s1;
  logic                 rx_s2;
  logic                 rx_d;
  logic                 active;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [3:0]           bit_idx;  // 0 start, 1..8 data, 9 parity, 10 stop.
  logic [7:0]           shreg;
  logic                 par_bit;
  logic                 half_tick;
  logic                 full_tick;
  logic                 frame_ok;

  assign half_tick = (bit_cnt == BIT_CNT_W'(HALF_BIT_CYCLES - 1));
  assign full_tick = (bit_cnt == BIT_CNT_W'(BIT_CYCLES - 1));

  // rx_s2 holds the stop bit when this is used.
  assign frame_ok = rx_s2 && ((^shreg) == par_bit);

  assign rx_link.data = shreg;  // Stable from the stop bit to the next frame.

  // Data bits arrive LSB first.
  always_ff @(posedge clk)
  begin
    if (active && (bit_idx != 4'd0) && full_tick)
    begin
      if (bit_idx <= 4'd8)
      begin
        shreg <= {rx_s2, shreg[7:1]};
      end
      else if (bit_idx == 4'd9)
      begin
        par_bit <= rx_s2;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1             <= 1'b1;
      rx_s2             <= 1'b1;
      rx_d              <= 1'b1;
      active            <= 1'b0;
      bit_cnt           <= '0;
      bit_idx           <= '0;
      rx_link.valid     <= 1'b0;
      rx_link.frame_err <= 1'b0;
    end
    else
    begin
      rx_s1             <= rx;
      rx_s2             <= rx_s1;
      rx_d              <= rx_s2;
      rx_link.valid     <= 1'b0;
      rx_link.frame_err <= 1'b0;

      if (!active)
      begin
        if (rx_link.enable && rx_d && !rx_s2)  // Falling edge.
        begin
          active  <= 1'b1;
          bit_cnt <= '0;
          bit_idx <= '0;
        end
      end
      else if (bit_idx == 4'd0)
      begin
        if (half_tick)
        begin
          bit_cnt <= '0;
          if (rx_s2)
          begin
            active <= 1'b0;  // Glitch, back to hunting.
          end
          else
          begin
            bit_idx <= 4'd1;
          end
        end
        else
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      else if (full_tick)
      begin
        bit_cnt <= '0;
        bit_idx <= bit_idx + 4'd1;
        if (bit_idx == 4'(FRAME_BITS - 1))
        begin
          active            <= 1'b0;
          rx_link.valid     <= frame_ok;
          rx_link.frame_err <= !frame_ok;
        end
      end
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/uart_tx_frame.sv */
`default_nettype none

module uart_tx_frame (
  input  logic       clk,
  input  logic       rst_n,
  uart_tx_if.framer  tx_link,
  output logic       tx
);
  import uart_cmd_pkg::*;

  logic [FRAME_BITS-1:0] frame;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [3:0]            bit_idx;
  logic                  load;
  logic                  last_tick;

  assign load      = tx_link.start && !tx_link.busy;
  assign last_tick = (bit_cnt == BIT_CNT_W'(BIT_CYCLES - 1));

  // Frame is shifted out from bit 0: start, data LSB first, parity, stop.
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      frame <= {1'b1, ^tx_link.data, tx_link.data, 1'b0};  // Even parity.
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_link.busy <= 1'b0;
      tx_link.done <= 1'b0;
      bit_cnt      <= '0;
      bit_idx      <= '0;
      tx           <= 1'b1;
    end
    else
    begin
      tx_link.done <= 1'b0;

      // Line follows the bit index one cycle late.
      tx <= tx_link.busy ? frame[bit_idx] : 1'b1;

      if (load)
      begin
        tx_link.busy <= 1'b1;
        bit_cnt      <= '0;
        bit_idx      <= '0;
      end
      else if (tx_link.busy)
      begin
        if (last_tick)
        begin
          bit_cnt <= '0;
          if (bit_idx == 4'(FRAME_BITS - 1))
          begin
            // tx still shows the stop bit for one more cycle.
            tx_link.busy <= 1'b0;
            tx_link.done <= 1'b1;
          end
          else
          begin
            bit_idx <= bit_idx + 4'd1;
          end
        end
        else
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/uart_frame_if.sv */
`default_nettype none

// Controller to transmitter.
interface uart_tx_if;
  logic       start;  // One-cycle request, data sampled here.
  logic [7:0] data;
  logic       busy;
  logic       done;   // Last cycle of the stop bit.

  modport ctrl (
    output start,
    output data,
    input  busy,
    input  done
  );

  modport framer (
    input  start,
    input  data,
    output busy,
    output done
  );
endinterface

// Controller to receiver.
interface uart_rx_if;
  logic       enable;     // Hunt for a start bit while high.
  logic [7:0] data;
  logic       valid;
  logic       frame_err;  // Bad parity or stop bit.

  modport ctrl (
    output enable,
    input  data,
    input  valid,
    input  frame_err
  );

  modport framer (
    input  enable,
    output data,
    output valid,
    output frame_err
  );
endinterface

`default_nettype wire

/* design/uart_cmd_pkg.sv */
`default_nettype none

package uart_cmd_pkg;

  // Serial timing, all in clock cycles.
  localparam int BIT_CYCLES          = 16;  // 434 for 115200 baud at 50 MHz.
  localparam int HALF_BIT_CYCLES     = BIT_CYCLES / 2;
  localparam int GAP_CYCLES          = 15 * BIT_CYCLES;
  localparam int RESP_TIMEOUT_CYCLES = 64 * BIT_CYCLES;

  // Start, eight data bits, parity, stop.
  localparam int FRAME_BITS = 11;

  localparam int BIT_CNT_W = $clog2(BIT_CYCLES);
  localparam int TMR_W     = $clog2(RESP_TIMEOUT_CYCLES);

  typedef struct packed {
    logic       is_write;
    logic [6:0] addr;
    logic [7:0] wdata;
  } cmd_fields_s;

  // Same word seen as fields or as the two bytes put on the line.
  // bytes[1] goes out first.
  typedef union packed {
    cmd_fields_s     fields;
    logic [1:0][7:0] bytes;
  } cmd_word_u;

  typedef enum logic [2:0] {
    IDLE,
    DECODE,
    WR_ADDR,
    WR_GAP,
    WR_DATA,
    RD_ADDR,
    RD_WAIT,
    RD_DONE
  } ctrl_state_e;

endpackage

`default_nettype wire
